/* Bender.yml */
package:
  name: des

sources:
  - design/des_pkg.sv
  - design/des_key_schedule.sv
  - design/des_input_stage.sv
  - design/des_feistel_f.sv
  - design/des_round_pipeline.sv
  - design/des.sv
  - target: test
    files:
      - dv/des_checker.sv
      - dv/des_tb.sv

/* compile.f */
design/des_pkg.sv
design/des_key_schedule.sv
design/des_input_stage.sv
design/des_feistel_f.sv
design/des_round_pipeline.sv
design/des.sv
dv/des_checker.sv
dv/des_tb.sv

/* design/des.sv */
`timescale 1ns/1ps

module des
	import des_pkg::*;
(
	input  logic   clock,
	input  logic   rst,
	input  block_t key,
	input  block_t plaintext,
	input  logic   iv,
	output block_t ciphertext,
	output logic   ov
);

	subkey_array_t round_keys;
	half_t         ip_left;
	half_t         ip_right;
	logic          ip_valid;

	// subkeys are combinational, so key must stay put while blocks are in flight
	des_key_schedule u_key_schedule (
		.key        (key),
		.round_keys (round_keys)
	);

	// the raw block takes one stage and the IP halves a second
	des_input_stage u_input_stage (
		.clock     (clock),
		.rst       (rst),
		.plaintext (plaintext),
		.iv        (iv),
		.left      (ip_left),
		.right     (ip_right),
		.valid     (ip_valid)
	);

	// sixteen rounds and the output register make up the rest of the 19 stages
	des_round_pipeline u_round_pipeline (
		.clock      (clock),
		.rst        (rst),
		.left       (ip_left),
		.right      (ip_right),
		.valid      (ip_valid),
		.round_keys (round_keys),
		.ciphertext (ciphertext),
		.ov         (ov)
	);

endmodule

/* design/des_feistel_f.sv */
`timescale 1ns/1ps

module des_feistel_f
	import des_pkg::*;
(
	input  half_t   right,
	input  subkey_t subkey,
	output half_t   f_out
);

	subkey_t expanded;
	subkey_t mixed;
	half_t   sbox_out;

	// E repeats the edge bits of each nibble to widen 32 bits to 48
	always_comb begin
		for (int i = 0; i < SUBKEY_W; i++) begin
			expanded[SUBKEY_W-1-i] = right[HALF_W - E_TABLE[i]];
		end
	end

	assign mixed = expanded ^ subkey;

	for (genvar b = 0; b < NUM_SBOXES; b++) begin : g_sbox
		logic [SBOX_IN_W-1:0] group;
		logic [SBOX_IN_W-1:0] index;

		assign group = mixed[SUBKEY_W-1-b*SBOX_IN_W -: SBOX_IN_W];

		// outer bits pick the row and the middle four the column
		assign index = {group[SBOX_IN_W-1], group[0], group[SBOX_IN_W-2:1]};

		assign sbox_out[HALF_W-1-b*SBOX_OUT_W -: SBOX_OUT_W] = SBOX_TABLE[b][index];
	end

	always_comb begin
		for (int i = 0; i < HALF_W; i++) begin
			f_out[HALF_W-1-i] = sbox_out[HALF_W - P_TABLE[i]];
		end
	end

endmodule

/* design/des_input_stage.sv */
`timescale 1ns/1ps

module des_input_stage
	import des_pkg::*;
(
	input  logic   clock,
	input  logic   rst,
	input  block_t plaintext,
	input  logic   iv,
	output half_t  left,
	output half_t  right,
	output logic   valid
);

	block_t in_q;
	logic   in_valid_q;
	block_t ip_block;

	always_comb begin
		for (int i = 0; i < BLOCK_W; i++) begin
			ip_block[BLOCK_W-1-i] = in_q[BLOCK_W - IP_TABLE[i]];
		end
	end

	// the first stage captures the block and the second holds the permuted halves
	always_ff @(posedge clock) begin
		if (rst) begin
			in_q       <= '0;
			in_valid_q <= 1'b0;
			left       <= '0;
			right      <= '0;
			valid      <= 1'b0;
		end else begin
			in_q       <= plaintext;
			in_valid_q <= iv;
			left       <= ip_block[BLOCK_W-1 -: HALF_W];
			right      <= ip_block[HALF_W-1:0];
			valid      <= in_valid_q;
		end
	end

endmodule

/* design/des_key_schedule.sv */
`timescale 1ns/1ps

module des_key_schedule
	import des_pkg::*;
(
	input  block_t        key,
	output subkey_array_t round_keys
);

	logic [2*CD_W-1:0] pc1_out;
	cd_half_t          c0;
	cd_half_t          d0;

	// PC-1 drops the parity bits and reorders the remaining 56
	always_comb begin
		for (int i = 0; i < 2*CD_W; i++) begin
			pc1_out[2*CD_W-1-i] = key[BLOCK_W - PC1_TABLE[i]];
		end
	end

	assign c0 = pc1_out[2*CD_W-1 -: CD_W];
	assign d0 = pc1_out[CD_W-1:0];

	for (genvar r = 1; r <= NUM_ROUNDS; r++) begin : g_round
		cd_half_t          c_prev;
		cd_half_t          d_prev;
		cd_half_t          c_rot;
		cd_half_t          d_rot;
		logic [2*CD_W-1:0] cd;
		subkey_t           subkey;

		if (r == 1) begin : g_first
			assign c_prev = c0;
			assign d_prev = d0;
		end else begin : g_next
			assign c_prev = g_round[r-1].c_rot;
			assign d_prev = g_round[r-1].d_rot;
		end

		// rotate each 28 bit half left by one or two places
		assign c_rot = (c_prev << SHIFT_SCHEDULE[r]) | (c_prev >> (CD_W - SHIFT_SCHEDULE[r]));
		assign d_rot = (d_prev << SHIFT_SCHEDULE[r]) | (d_prev >> (CD_W - SHIFT_SCHEDULE[r]));
		assign cd    = {c_rot, d_rot};

		always_comb begin
			for (int i = 0; i < SUBKEY_W; i++) begin
				subkey[SUBKEY_W-1-i] = cd[2*CD_W - PC2_TABLE[i]];
			end
		end

		assign round_keys[r] = subkey;
	end

endmodule

/* design/des_pkg.sv */
package des_pkg;

	localparam int BLOCK_W    = 64;
	localparam int HALF_W     = 32;
	localparam int SUBKEY_W   = 48;
	localparam int CD_W       = 28;
	localparam int NUM_ROUNDS = 16;
	localparam int NUM_SBOXES = 8;
	localparam int SBOX_IN_W  = 6;
	localparam int SBOX_OUT_W = 4;

	typedef logic [BLOCK_W-1:0]  block_t;
	typedef logic [HALF_W-1:0]   half_t;
	typedef logic [SUBKEY_W-1:0] subkey_t;
	typedef logic [CD_W-1:0]     cd_half_t;
	typedef logic [1:NUM_ROUNDS][SUBKEY_W-1:0] subkey_array_t;

	// left rotation applied to C and D before each round
	localparam int SHIFT_SCHEDULE [1:NUM_ROUNDS] = '{
		1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
	};

	// all tables list source bits in DES numbering, bit 1 being the msb
	localparam int IP_TABLE [BLOCK_W] = '{
		58, 50, 42, 34, 26, 18, 10, 2,
		60, 52, 44, 36, 28, 20, 12, 4,
		62, 54, 46, 38, 30, 22, 14, 6,
		64, 56, 48, 40, 32, 24, 16, 8,
		57, 49, 41, 33, 25, 17,  9, 1,
		59, 51, 43, 35, 27, 19, 11, 3,
		61, 53, 45, 37, 29, 21, 13, 5,
		63, 55, 47, 39, 31, 23, 15, 7
	};

	// inverse of IP
	localparam int FP_TABLE [BLOCK_W] = '{
		40, 8, 48, 16, 56, 24, 64, 32,
		39, 7, 47, 15, 55, 23, 63, 31,
		38, 6, 46, 14, 54, 22, 62, 30,
		37, 5, 45, 13, 53, 21, 61, 29,
		36, 4, 44, 12, 52, 20, 60, 28,
		35, 3, 43, 11, 51, 19, 59, 27,
		34, 2, 42, 10, 50, 18, 58, 26,
		33, 1, 41,  9, 49, 17, 57, 25
	};

	localparam int E_TABLE [SUBKEY_W] = '{
		32,  1,  2,  3,  4,  5,
		 4,  5,  6,  7,  8,  9,
		 8,  9, 10, 11, 12, 13,
		12, 13, 14, 15, 16, 17,
		16, 17, 18, 19, 20, 21,
		20, 21, 22, 23, 24, 25,
		24, 25, 26, 27, 28, 29,
		28, 29, 30, 31, 32,  1
	};

	localparam int P_TABLE [HALF_W] = '{
		16,  7, 20, 21, 29, 12, 28, 17,
		 1, 15, 23, 26,  5, 18, 31, 10,
		 2,  8, 24, 14, 32, 27,  3,  9,
		19, 13, 30,  6, 22, 11,  4, 25
	};

	// parity bits 8, 16, ... 64 are never selected
	localparam int PC1_TABLE [2*CD_W] = '{
		57, 49, 41, 33, 25, 17,  9,
		 1, 58, 50, 42, 34, 26, 18,
		10,  2, 59, 51, 43, 35, 27,
		19, 11,  3, 60, 52, 44, 36,
		63, 55, 47, 39, 31, 23, 15,
		 7, 62, 54, 46, 38, 30, 22,
		14,  6, 61, 53, 45, 37, 29,
		21, 13,  5, 28, 20, 12,  4
	};

	localparam int PC2_TABLE [SUBKEY_W] = '{
		14, 17, 11, 24,  1,  5,
		 3, 28, 15,  6, 21, 10,
		23, 19, 12,  4, 26,  8,
		16,  7, 27, 20, 13,  2,
		41, 52, 31, 37, 47, 55,
		30, 40, 51, 45, 33, 48,
		44, 49, 39, 56, 34, 53,
		46, 42, 50, 36, 29, 32
	};

	// each box holds four rows of sixteen, so the index is row * 16 + column
	localparam logic [SBOX_OUT_W-1:0] SBOX_TABLE [NUM_SBOXES][2**SBOX_IN_W] = '{
		// S1
		'{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
		   0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
		   4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
		  15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
		// S2
		'{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
		   3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
		   0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
		  13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
		// S3
		'{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
		  13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
		  13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
		   1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
		// S4
		'{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
		  13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
		  10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
		   3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
		// S5
		'{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
		  14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
		   4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
		  11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
		// S6
		'{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
		  10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
		   9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
		   4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
		// S7
		'{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
		  13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
		   1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
		   6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
		// S8
		'{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
		   1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
		   7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
		   2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
	};

endpackage

/* design/des_round_pipeline.sv */
`timescale 1ns/1ps

module des_round_pipeline
	import des_pkg::*;
(
	input  logic          clock,
	input  logic          rst,
	input  half_t         left,
	input  half_t         right,
	input  logic          valid,
	input  subkey_array_t round_keys,
	output block_t        ciphertext,
	output logic          ov
);

	block_t preout;
	block_t fp_block;

	// each round has one register stage and the valid bit moves along with the halves
	for (genvar r = 1; r <= NUM_ROUNDS; r++) begin : g_round
		half_t l_prev;
		half_t r_prev;
		logic  v_prev;
		half_t f_val;
		half_t l_q;
		half_t r_q;
		logic  v_q;

		if (r == 1) begin : g_first
			assign l_prev = left;
			assign r_prev = right;
			assign v_prev = valid;
		end else begin : g_next
			assign l_prev = g_round[r-1].l_q;
			assign r_prev = g_round[r-1].r_q;
			assign v_prev = g_round[r-1].v_q;
		end

		des_feistel_f u_feistel_f (
			.right  (r_prev),
			.subkey (round_keys[r]),
			.f_out  (f_val)
		);

		always_ff @(posedge clock) begin
			if (rst) begin
				l_q <= '0;
				r_q <= '0;
				v_q <= 1'b0;
			end else begin
				l_q <= r_prev;
				r_q <= l_prev ^ f_val;
				v_q <= v_prev;
			end
		end
	end

	// the last round is undone by swapping the halves before FP
	assign preout = {g_round[NUM_ROUNDS].r_q, g_round[NUM_ROUNDS].l_q};

	always_comb begin
		for (int i = 0; i < BLOCK_W; i++) begin
			fp_block[BLOCK_W-1-i] = preout[BLOCK_W - FP_TABLE[i]];
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			ciphertext <= '0;
			ov         <= 1'b0;
		end else begin
			// ciphertext only changes when a valid block leaves the last round
			if (g_round[NUM_ROUNDS].v_q) begin
				ciphertext <= fp_block;
			end
			ov <= g_round[NUM_ROUNDS].v_q;
		end
	end

endmodule

/* dv/des_checker.sv */
`timescale 1ns/1ps

module des_checker
	import des_pkg::*;
(
	input  logic   clock,
	input  logic   rst,
	input  logic   iv,
	input  block_t plaintext,
	input  block_t key,
	input  logic   ov,
	input  block_t ciphertext,
	input  block_t exp_value,
	input  logic   exp_known,
	input  logic   done,
	output logic   finished,
	output int     value_errors,
	output int     protocol_errors,
	output int     results
);

	// edges from the one that samples iv to the one that raises ov
	localparam int LATENCY = 18;

	block_t exp_q [$];
	logic   known_q [$];
	int     edge_q [$];
	block_t pt_q [$];
	int     edge_cnt;
	int     iv_pulses;
	int     ov_pulses;
	int     age;
	logic   rst_seen;
	logic   got_result;
	block_t last_key;

	initial begin
		finished        = 1'b0;
		value_errors    = 0;
		protocol_errors = 0;
		results         = 0;
		edge_cnt        = 0;
		iv_pulses       = 0;
		ov_pulses       = 0;
		rst_seen        = 1'b0;
		got_result      = 1'b0;
		last_key        = '0;
	end

	task automatic drop_oldest;
		void'(exp_q.pop_front());
		void'(known_q.pop_front());
		void'(edge_q.pop_front());
		void'(pt_q.pop_front());
	endtask

	// inputs change 1 ns after the edge, so they are stable here
	always @(posedge clock) begin
		edge_cnt++;
		rst_seen = rst;
		if (!rst) begin
			// the subkeys are combinational and cannot follow a key change
			if (exp_q.size() > 0 && key !== last_key) begin
				protocol_errors++;
				$display("key changed at %0t while %0d blocks were in flight",
					$time, exp_q.size());
			end
			if (iv === 1'b1) begin
				exp_q.push_back(exp_value);
				known_q.push_back(exp_known);
				edge_q.push_back(edge_cnt);
				pt_q.push_back(plaintext);
				iv_pulses++;
			end
		end
		last_key = key;
		if (done && !finished) begin
			if (iv_pulses != ov_pulses) begin
				protocol_errors++;
				$display("%0d blocks were issued but %0d results came back",
					iv_pulses, ov_pulses);
			end
			if (exp_q.size() != 0) begin
				protocol_errors++;
				$display("%0d blocks were still in flight at the end", exp_q.size());
			end
			finished = 1'b1;
		end
	end

	// outputs settle after the rising edge and are read half a cycle later
	always @(negedge clock) begin
		if (rst_seen) begin
			got_result = 1'b0;
			if (ov !== 1'b0) begin
				protocol_errors++;
				$display("ov was high at %0t while reset was applied", $time);
			end
			if (ciphertext !== '0) begin
				value_errors++;
				$display("ERR %0t ciphertext got %h expected %h", $time, ciphertext, 64'h0);
			end
		end else if (ov === 1'b1) begin
			ov_pulses++;
			got_result = 1'b1;
			if (exp_q.size() == 0) begin
				protocol_errors++;
				$display("ov at %0t with no block in flight", $time);
			end else begin
				age = edge_cnt - edge_q[0];
				if (age != LATENCY) begin
					value_errors++;
					$display("ERR %0t ov_latency got %0d expected %0d", $time, age, LATENCY);
				end
				if (known_q[0] && ciphertext !== exp_q[0]) begin
					value_errors++;
					$display("ERR %0t ciphertext got %h expected %h",
						$time, ciphertext, exp_q[0]);
				end
				results++;
				drop_oldest();
			end
		end else begin
			// ciphertext stays zero from reset until the first block comes out
			if (!got_result && ciphertext !== '0) begin
				value_errors++;
				$display("ERR %0t ciphertext got %h expected %h", $time, ciphertext, 64'h0);
			end
			if (exp_q.size() > 0 && edge_cnt - edge_q[0] >= LATENCY) begin
				protocol_errors++;
				$display("no ov for plaintext %h issued at edge %0d", pt_q[0], edge_q[0]);
				drop_oldest();
			end
		end
	end

endmodule

/* dv/des_tb.sv */
`timescale 1ns/1ps

module des_tb
	import des_pkg::*;
();

	localparam int RST_CYCLES = 16;
	localparam int LATENCY    = 19;
	localparam int MAX_ROWS   = 16;
	localparam int NUM_WEAK   = 6;

	localparam block_t KEY_STD  = 64'h133457799BBCDFF1;
	localparam block_t PT_STD   = 64'h0123456789ABCDEF;
	localparam block_t CT_STD   = 64'h85E813540F0AB405;
	localparam block_t CT_ZERO  = 64'h8CA64DE9C1B123A7;
	localparam block_t CT_ONES  = 64'h7359B2163E4EDC58;
	localparam block_t ALL_ONES = 64'hFFFFFFFFFFFFFFFF;
	localparam block_t WEAK_KEY = 64'h0101010101010101;

	logic   clock;
	logic   rst;
	block_t key;
	block_t plaintext;
	logic   iv;
	block_t ciphertext;
	logic   ov;
	block_t exp_value;
	logic   exp_known;
	logic   done;
	logic   finished;
	int     value_errors;
	int     protocol_errors;
	int     results;

	block_t      tab_key [MAX_ROWS];
	block_t      tab_pt [MAX_ROWS];
	block_t      tab_exp [MAX_ROWS];
	int          tab_gap [MAX_ROWS];
	int          num_rows;
	block_t      returned_q [$];
	block_t      weak_pt [NUM_WEAK];
	block_t      rnd;
	int          issued;
	int          returned;
	int          cycles;
	int          cycle_limit;
	int          drains;
	int          total_gaps;
	int          base;
	logic [31:0] lfsr;

	des des_i (
		.clock      (clock),
		.rst        (rst),
		.key        (key),
		.plaintext  (plaintext),
		.iv         (iv),
		.ciphertext (ciphertext),
		.ov         (ov)
	);

	des_checker des_checker_i (
		.clock           (clock),
		.rst             (rst),
		.iv              (iv),
		.plaintext       (plaintext),
		.key             (key),
		.ov              (ov),
		.ciphertext      (ciphertext),
		.exp_value       (exp_value),
		.exp_known       (exp_known),
		.done            (done),
		.finished        (finished),
		.value_errors    (value_errors),
		.protocol_errors (protocol_errors),
		.results         (results)
	);

	always #2 clock = ~clock;

	// results are kept so the weak key blocks can be sent through again
	always @(negedge clock) begin
		if (!rst && ov === 1'b1) begin
			returned_q.push_back(ciphertext);
			returned++;
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles with %0d of %0d blocks returned",
				cycles, returned, issued);
			$display("** FAIL **");
			$finish;
		end
	end

	// Galois form of x^32 + x^22 + x^2 + x + 1 that shifts right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h80200003;
		return n;
	endfunction

	task automatic random_block(output block_t b);
		b = '0;
		for (int i = 0; i < 64; i++) begin
			lfsr = lfsr_next(lfsr);
			b = {b[62:0], lfsr[0]};
		end
	endtask

	task automatic add_row(input block_t k, input block_t pt, input block_t exp, input int gap);
		tab_key[num_rows] = k;
		tab_pt[num_rows]  = pt;
		tab_exp[num_rows] = exp;
		tab_gap[num_rows] = gap;
		num_rows++;
	endtask

	task automatic issue_block(input block_t k, input block_t pt, input block_t exp,
		input logic known);
		key       = k;
		plaintext = pt;
		exp_value = exp;
		exp_known = known;
		iv        = 1'b1;
		issued++;
		@(posedge clock);
		#1;
		iv        = 1'b0;
		exp_known = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
		end
	endtask

	// the key may only change once every block in flight has come out
	task automatic wait_drained;
		while (returned < issued)
			@(posedge clock);
		@(posedge clock);
		#1;
	endtask

	initial begin
		clock     = 1'b0;
		rst       = 1'b1;
		iv        = 1'b0;
		key       = '0;
		plaintext = '0;
		exp_value = '0;
		exp_known = 1'b0;
		done      = 1'b0;
		issued    = 0;
		returned  = 0;
		cycles    = 0;
		num_rows  = 0;
		lfsr      = 32'he7818f53;

		add_row(KEY_STD, PT_STD, CT_STD, 0);
		add_row(KEY_STD, PT_STD, CT_STD, 2);
		add_row(~KEY_STD, ~PT_STD, ~CT_STD, 0);
		add_row(~KEY_STD, ~PT_STD, ~CT_STD, 4);
		// the all zero key is weak, so its ciphertext encrypts back to zero
		add_row(64'h0, 64'h0, CT_ZERO, 0);
		add_row(64'h0, CT_ZERO, 64'h0, 0);
		add_row(64'h0, 64'h0, CT_ZERO, 0);
		add_row(64'h0, CT_ZERO, 64'h0, 3);
		add_row(ALL_ONES, ALL_ONES, CT_ONES, 0);
		add_row(ALL_ONES, CT_ONES, ALL_ONES, 0);
		add_row(~64'h0, ~64'h0, ~CT_ZERO, 1);
		add_row(ALL_ONES, ALL_ONES, CT_ONES, 0);

		// every key change and every weak key pass waits out the pipeline
		total_gaps = 0;
		drains     = 3;
		for (int i = 0; i < num_rows; i++) begin
			total_gaps += tab_gap[i];
			if (i > 0 && tab_key[i] != tab_key[i-1])
				drains++;
		end
		cycle_limit = RST_CYCLES + num_rows + 2 * NUM_WEAK + total_gaps
			+ LATENCY * drains + 50;

		// a few strobes land inside reset and must not produce results
		for (int i = 0; i < RST_CYCLES; i++) begin
			@(posedge clock);
			#1;
			iv        = (i >= RST_CYCLES - 5 && i < RST_CYCLES - 1);
			plaintext = PT_STD;
		end
		rst = 1'b0;

		for (int r = 0; r < num_rows; r++) begin
			if (r > 0 && tab_key[r] != tab_key[r-1])
				wait_drained();
			issue_block(tab_key[r], tab_pt[r], tab_exp[r], 1'b1);
			idle_cycles(tab_gap[r]);
		end

		wait_drained();
		base = returned;
		for (int i = 0; i < NUM_WEAK; i++) begin
			random_block(rnd);
			weak_pt[i] = rnd;
			issue_block(WEAK_KEY, rnd, '0, 1'b0);
		end
		wait_drained();
		for (int i = 0; i < NUM_WEAK; i++)
			issue_block(WEAK_KEY, returned_q[base + i], weak_pt[i], 1'b1);
		wait_drained();

		done = 1'b1;
		while (!finished)
			@(negedge clock);
		$display("value errors %0d, protocol errors %0d, results %0d of %0d blocks",
			value_errors, protocol_errors, results, issued);
		if (value_errors == 0 && protocol_errors == 0 && results == issued) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule
